// ==== bench/tap_tb_tasks.svh ====
/*
 * TAP testbench tasks
 * TMS/TDI stepping, LFSR stimulus, compare tasks and the directed tests
 */

`ifndef TAP_TB_TASKS_SVH
`define TAP_TB_TASKS_SVH

// ------------------------------------------------------------
// Stimulus
// ------------------------------------------------------------

// Fibonacci LFSR with taps 32 22 2 1 shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[0] ^ s[10] ^ s[30] ^ s[31], s[31:1]};
endfunction

// One LFSR step per bit taken
task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits[i] = lfsr_q[0];
        lfsr_q  = lfsr_next(lfsr_q);
    end
endtask

// Drive on the falling edge and sample TDO on the next rising edge
task automatic tms_step(input logic tms_val, input logic tdi_val,
                        output logic tdo_val, output logic en_val);
    @(negedge tapc_tck);
    tms = tms_val;
    tdi = tdi_val;
    @(posedge tapc_tck);
    tdo_val = tdo;
    en_val  = tdo_en;
endtask

// Five TMS highs reach Test-Logic-Reset from anywhere
task automatic goto_reset();
    logic b;
    logic e;
    repeat (5) tms_step(1'b1, 1'b0, b, e);
endtask

// Idle to Idle through Shift-IR returning the captured bits
task automatic shift_ir(input logic [IR_W-1:0] instr, output logic [IR_W-1:0] captured);
    logic b;
    logic e;
    tms_step(1'b1, 1'b0, b, e);
    tms_step(1'b1, 1'b0, b, e);
    tms_step(1'b0, 1'b0, b, e);
    tms_step(1'b0, 1'b0, b, e);
    // Last bit leaves for Exit1-IR
    for (int i = 0; i < IR_W; i++) begin
        tms_step(i == IR_W - 1, instr[i], captured[i], e);
    end
    tms_step(1'b1, 1'b0, b, e);
    tms_step(1'b0, 1'b0, b, e);
endtask

// Idle to Idle through Shift-DR with up to 32 bits
task automatic shift_dr(input int n, input logic [31:0] data_in,
                        output logic [31:0] data_out, output logic en_all);
    logic b;
    logic e;
    data_out = '0;
    en_all   = 1'b1;
    tms_step(1'b1, 1'b0, b, e);
    tms_step(1'b0, 1'b0, b, e);
    tms_step(1'b0, 1'b0, b, e);
    for (int i = 0; i < n; i++) begin
        tms_step(i == n - 1, data_in[i], data_out[i], e);
        en_all = en_all & e;
    end
    tms_step(1'b1, 1'b0, b, e);
    tms_step(1'b0, 1'b0, b, e);
endtask

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_idcode(input string name, input idcode_t got, input idcode_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------

// TDO stays quiet with TMS held high
task automatic reset_outputs_quiet();
    logic b;
    logic e;
    for (int i = 0; i < 4; i++) begin
        tms_step(1'b1, 1'b0, b, e);
        check_bit("tdo_o in reset", b, 1'b0);
        check_bit("tdo_en_o in reset", e, 1'b0);
    end
endtask

// IDCODE is the reset instruction
task automatic idcode_after_reset();
    logic b;
    logic e;
    logic [31:0] got;
    tms_step(1'b0, 1'b0, b, e);
    shift_dr(32, 32'h0, got, e);
    check_idcode("tdo_o idcode word", got, fuse_idcode);
    check_bit("tdo_en_o during Shift-DR", e, 1'b1);
endtask

// Capture pattern is 1 then zeros
// IDCODE is shifted back in so the instruction stays the same
task automatic ir_capture_pattern();
    logic [IR_W-1:0] got;
    shift_ir(IR_W'(INSTR_IDCODE), got);
    for (int i = 0; i < IR_W; i++) begin
        check_bit($sformatf("tdo_o ir capture bit %0d", i), got[i], i == 0);
    end
endtask

// BYPASS returns 0 then TDI one bit late
task automatic bypass_delay();
    logic [IR_W-1:0] cap;
    logic [31:0] pattern;
    logic [31:0] got;
    logic e;
    take_bits(BYP_BITS, pattern);
    shift_ir('1, cap);
    // Leave a 1 in the BYPASS bit so Capture-DR has to clear it
    shift_dr(1, 32'h1, got, e);
    shift_dr(BYP_BITS, pattern, got, e);
    check_bit("tdo_o bypass bit 0", got[0], 1'b0);
    for (int i = 1; i < BYP_BITS; i++) begin
        check_bit($sformatf("tdo_o bypass bit %0d", i), got[i], pattern[i-1]);
    end
    check_bit("tdo_en_o during bypass", e, 1'b1);
endtask

// Soft reset puts IDCODE back
task automatic tms_reset_restores_idcode();
    logic [IR_W-1:0] cap;
    logic [31:0] got;
    logic b;
    logic e;
    shift_ir(IR_W'(2), cap);
    goto_reset();
    tms_step(1'b0, 1'b0, b, e);
    shift_dr(32, 32'h0, got, e);
    check_idcode("tdo_o idcode after reset", got, fuse_idcode);
endtask

`endif

// ==== bench/tap_tb.sv ====
/*
 * TAP controller testbench
 * Directed JTAG sequences against tap_top, guarded by a watchdog
 */

`timescale 1ns/1ns

module tap_tb;

    import tap_pkg::*;

    localparam int IR_W         = IR_WIDTH_DEFAULT;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int BYP_BITS     = 24;
    // Reset, quiet check, IDCODE read, IR capture, bypass, TMS reset
    localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 38 + 3 * (IR_W + 6)
                                  + (BYP_BITS + 11) + 43;

    logic        tapc_tck;
    logic        tapc_trst_n;
    logic        tms;
    logic        tdi;
    idcode_t     fuse_idcode;
    logic        tdo;
    logic        tdo_en;

    int          error_count;
    int          check_count;
    logic [31:0] lfsr_q;

    `include "tap_tb_tasks.svh"

    // ------------------------------------------------------------
    // DUT
    // ------------------------------------------------------------

    tap_top #(.IR_WIDTH(IR_W)) dut0 (
        .tapc_tck      (tapc_tck),
        .tapc_trst_n   (tapc_trst_n),
        .tms_i         (tms),
        .tdi_i         (tdi),
        .fuse_idcode_i (fuse_idcode),
        .tdo_o         (tdo),
        .tdo_en_o      (tdo_en)
    );

    // 100 ns TCK
    always #(CLK_PERIOD / 2) tapc_tck = ~tapc_tck;

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        tapc_tck    = 1'b0;
        tapc_trst_n = 1'b0;
        tms         = 1'b1;
        tdi         = 1'b0;
        error_count = 0;
        check_count = 0;
        lfsr_q      = 32'hbcb4_db56;
        take_bits(32, fuse_idcode);
        // Release on a falling edge
        repeat (RESET_CYCLES) @(negedge tapc_tck);
        tapc_trst_n = 1'b1;

        reset_outputs_quiet();
        idcode_after_reset();
        ir_capture_pattern();
        bypass_delay();
        tms_reset_restores_idcode();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Twice the expected length of the run
    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Watchdog: the run timed out before the tests finished");
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Testbench failed");
        $finish;
    end

endmodule : tap_tb

// ==== project.f ====
+incdir+bench
src/tap_pkg.sv
src/tap_fsm.sv
src/tap_ir.sv
src/tap_idcode_reg.sv
src/tap_tdo_out.sv
src/tap_top.sv
bench/tap_tb.sv

// ==== src/tap_fsm.sv ====
/*
 * TAP controller state machine
 * Sixteen-state IEEE 1149.1 FSM, soft reset out of Test-Logic-Reset
 * and the capture, shift and update flags for the datapath
 */

`timescale 1ns/1ns

module tap_fsm (
    input  logic tapc_tck,
    input  logic tapc_trst_n,
    input  logic tms_i,
    output logic soft_rst_n_o,
    output logic ir_capture_o,
    output logic ir_shift_o,
    output logic ir_update_o,
    output logic ir_shift_q_o,
    output logic dr_capture_q_o,
    output logic dr_shift_q_o
);

    import tap_pkg::*;

    tap_state_e state_q;
    tap_state_e state_d;

    // ----------------------------------------------------------
    // Soft reset
    // ----------------------------------------------------------

    // Registered on the falling edge to settle before the next rising edge
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            soft_rst_n_o <= 1'b0;
        end else begin
            soft_rst_n_o <= (state_q != TAP_RESET);
        end
    end

    // ----------------------------------------------------------
    // State register and transitions
    // ----------------------------------------------------------

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            state_q <= TAP_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Standard 1149.1 state graph
    // Five TMS highs end in reset from any state
    always_comb begin
        case (state_q)
            TAP_RESET:      state_d = tms_i ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       state_d = tms_i ? TAP_DR_SELECT : TAP_IDLE;
            TAP_DR_SELECT:  state_d = tms_i ? TAP_IR_SELECT : TAP_DR_CAPTURE;
            TAP_DR_CAPTURE: state_d = tms_i ? TAP_DR_EXIT1  : TAP_DR_SHIFT;
            TAP_DR_SHIFT:   state_d = tms_i ? TAP_DR_EXIT1  : TAP_DR_SHIFT;
            TAP_DR_EXIT1:   state_d = tms_i ? TAP_DR_UPDATE : TAP_DR_PAUSE;
            TAP_DR_PAUSE:   state_d = tms_i ? TAP_DR_EXIT2  : TAP_DR_PAUSE;
            TAP_DR_EXIT2:   state_d = tms_i ? TAP_DR_UPDATE : TAP_DR_SHIFT;
            TAP_DR_UPDATE:  state_d = tms_i ? TAP_DR_SELECT : TAP_IDLE;
            TAP_IR_SELECT:  state_d = tms_i ? TAP_RESET     : TAP_IR_CAPTURE;
            TAP_IR_CAPTURE: state_d = tms_i ? TAP_IR_EXIT1  : TAP_IR_SHIFT;
            TAP_IR_SHIFT:   state_d = tms_i ? TAP_IR_EXIT1  : TAP_IR_SHIFT;
            TAP_IR_EXIT1:   state_d = tms_i ? TAP_IR_UPDATE : TAP_IR_PAUSE;
            TAP_IR_PAUSE:   state_d = tms_i ? TAP_IR_EXIT2  : TAP_IR_PAUSE;
            TAP_IR_EXIT2:   state_d = tms_i ? TAP_IR_UPDATE : TAP_IR_SHIFT;
            TAP_IR_UPDATE:  state_d = tms_i ? TAP_DR_SELECT : TAP_IDLE;
            default:        state_d = TAP_RESET;
        endcase
    end

    // IR flags decoded from the current state
    assign ir_capture_o = (state_q == TAP_IR_CAPTURE);
    assign ir_shift_o   = (state_q == TAP_IR_SHIFT);
    assign ir_update_o  = (state_q == TAP_IR_UPDATE);

    // ----------------------------------------------------------
    // Registered flags
    // ----------------------------------------------------------

    // Decoded from the next state
    // Each flag is high for the whole cycle spent in its state
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_shift_q_o   <= 1'b0;
            dr_capture_q_o <= 1'b0;
            dr_shift_q_o   <= 1'b0;
        end else begin
            ir_shift_q_o   <= (state_d == TAP_IR_SHIFT);
            dr_capture_q_o <= (state_d == TAP_DR_CAPTURE);
            dr_shift_q_o   <= (state_d == TAP_DR_SHIFT);
        end
    end

endmodule : tap_fsm

// ==== src/tap_idcode_reg.sv ====
/*
 * IDCODE data register
 * 32-bit device ID, loaded from the fuse value in Capture-DR
 * and shifted out LSB first in Shift-DR
 */

`timescale 1ns/1ns

module tap_idcode_reg (
    input  logic             tapc_tck,
    input  logic             tapc_trst_n,
    input  logic             soft_rst_n_i,
    input  logic             tdi_i,
    input  logic             select_i,
    input  logic             capture_i,
    input  logic             shift_i,
    input  tap_pkg::idcode_t capture_data_i,
    output logic             tdo_o
);

    import tap_pkg::*;

    idcode_t dr_q;

    // ----------------------------------------------------------
    // Capture and shift
    // ----------------------------------------------------------

    // Idle unless IDCODE is the current instruction
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            dr_q <= '0;
        end else if (!soft_rst_n_i) begin
            dr_q <= '0;
        end else if (select_i && capture_i) begin
            dr_q <= capture_data_i;
        end else if (select_i && shift_i) begin
            dr_q <= {tdi_i, dr_q[$bits(idcode_t)-1:1]};
        end
    end

    // Serial out
    assign tdo_o = dr_q[0];

endmodule : tap_idcode_reg

// ==== src/tap_ir.sv ====
/*
 * TAP instruction register
 * Shift stage loaded with the capture pattern and shifted from TDI,
 * plus the instruction register updated in Update-IR
 */

`timescale 1ns/1ns

module tap_ir #(
    parameter int IR_WIDTH = 5
) (
    input  logic                tapc_tck,
    input  logic                tapc_trst_n,
    input  logic                soft_rst_n_i,
    input  logic                tdi_i,
    input  logic                ir_capture_i,
    input  logic                ir_shift_i,
    input  logic                ir_update_i,
    output logic [IR_WIDTH-1:0] ir_o,
    output logic                ir_tdo_o
);

    import tap_pkg::*;

    // Capture pattern, only bit 0 set as 1149.1 requires
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = IR_WIDTH'(1);
    localparam logic [IR_WIDTH-1:0] IR_RESET   = IR_WIDTH'(INSTR_IDCODE);

    logic [IR_WIDTH-1:0] shift_q;

    // ----------------------------------------------------------
    // Shift stage, LSB out first
    // ----------------------------------------------------------

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            shift_q <= '0;
        end else if (!soft_rst_n_i) begin
            shift_q <= '0;
        end else if (ir_capture_i) begin
            shift_q <= IR_CAPTURE;
        end else if (ir_shift_i) begin
            // TDI enters at the top
            shift_q <= {tdi_i, shift_q[IR_WIDTH-1:1]};
        end
    end

    assign ir_tdo_o = shift_q[0];

    // ----------------------------------------------------------
    // Instruction register
    // ----------------------------------------------------------

    // Falling edge in Update-IR
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_o <= IR_RESET;
        end else if (!soft_rst_n_i) begin
            ir_o <= IR_RESET;
        end else if (ir_update_i) begin
            ir_o <= shift_q;
        end
    end

endmodule : tap_ir

// ==== src/tap_pkg.sv ====
/*
 * TAP controller shared definitions
 * State encoding of the IEEE 1149.1 controller, the device ID type
 * and the instruction constants used across the datapath
 */

package tap_pkg;

    // ----------------------------------------------------------
    // TAP controller states
    // ----------------------------------------------------------

    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        // DR column
        TAP_DR_SELECT,
        TAP_DR_CAPTURE,
        TAP_DR_SHIFT,
        TAP_DR_EXIT1,
        TAP_DR_PAUSE,
        TAP_DR_EXIT2,
        TAP_DR_UPDATE,
        // IR column
        TAP_IR_SELECT,
        TAP_IR_CAPTURE,
        TAP_IR_SHIFT,
        TAP_IR_EXIT1,
        TAP_IR_PAUSE,
        TAP_IR_EXIT2,
        TAP_IR_UPDATE
    } tap_state_e;

    // ----------------------------------------------------------
    // Data registers and instructions
    // ----------------------------------------------------------

    // Device identification value, captured from fuses
    typedef logic [31:0] idcode_t;

    // IDCODE opcode, also the IR value after reset
    // Any other opcode selects BYPASS
    localparam int INSTR_IDCODE = 1;

    // Default instruction width
    localparam int IR_WIDTH_DEFAULT = 5;

endpackage : tap_pkg

// ==== src/tap_tdo_out.sv ====
/*
 * TAP data register select and TDO output stage
 * Instruction decode, BYPASS bit, serial mux and the
 * falling-edge TDO and TDO enable registers
 */

`timescale 1ns/1ns

module tap_tdo_out #(
    parameter int IR_WIDTH = 5
) (
    input  logic                tapc_tck,
    input  logic                tapc_trst_n,
    input  logic                soft_rst_n_i,
    input  logic                tdi_i,
    input  logic [IR_WIDTH-1:0] ir_i,
    input  logic                ir_tdo_i,
    input  logic                idcode_tdo_i,
    input  logic                ir_shift_q_i,
    input  logic                dr_capture_q_i,
    input  logic                dr_shift_q_i,
    output logic                idcode_sel_o,
    output logic                tdo_o,
    output logic                tdo_en_o
);

    import tap_pkg::*;

    logic bypass_sel;
    logic bypass_q;
    logic dr_tdo;

    // ----------------------------------------------------------
    // Instruction decode
    // ----------------------------------------------------------

    // Anything that is not IDCODE falls back to BYPASS
    assign idcode_sel_o = (ir_i == IR_WIDTH'(INSTR_IDCODE));
    assign bypass_sel   = !idcode_sel_o;

    // BYPASS bit captures 0 and then delays TDI by one cycle
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            bypass_q <= 1'b0;
        end else if (!soft_rst_n_i) begin
            bypass_q <= 1'b0;
        end else if (bypass_sel && dr_capture_q_i) begin
            bypass_q <= 1'b0;
        end else if (bypass_sel && dr_shift_q_i) begin
            bypass_q <= tdi_i;
        end
    end

    assign dr_tdo = idcode_sel_o ? idcode_tdo_i : bypass_q;

    // ----------------------------------------------------------
    // TDO output registers
    // ----------------------------------------------------------

    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tdo_en_o <= 1'b0;
            tdo_o    <= 1'b0;
        end else begin
            tdo_en_o <= dr_shift_q_i || ir_shift_q_i;
            // DR shift has priority over IR shift
            // Driven low outside both shift states
            tdo_o    <= dr_shift_q_i ? dr_tdo : (ir_shift_q_i ? ir_tdo_i : 1'b0);
        end
    end

endmodule : tap_tdo_out

// ==== src/tap_top.sv ====
/*
 * TAP controller top level
 * FSM plus instruction register, IDCODE register and TDO stage
 */

`timescale 1ns/1ns

module tap_top #(
    parameter int IR_WIDTH = tap_pkg::IR_WIDTH_DEFAULT
) (
    input  logic             tapc_tck,
    input  logic             tapc_trst_n,
    input  logic             tms_i,
    input  logic             tdi_i,
    input  tap_pkg::idcode_t fuse_idcode_i,
    output logic             tdo_o,
    output logic             tdo_en_o
);

    // Controller outputs
    logic soft_rst_n;
    logic ir_capture;
    logic ir_shift;
    logic ir_update;
    logic ir_shift_q;
    logic dr_capture_q;
    logic dr_shift_q;

    // Datapath
    logic [IR_WIDTH-1:0] ir;
    logic                ir_tdo;
    logic                idcode_tdo;
    logic                idcode_sel;

    // ----------------------------------------------------------
    // Controller
    // ----------------------------------------------------------

    tap_fsm u_fsm (
        .tapc_tck       (tapc_tck),
        .tapc_trst_n    (tapc_trst_n),
        .tms_i          (tms_i),
        .soft_rst_n_o   (soft_rst_n),
        .ir_capture_o   (ir_capture),
        .ir_shift_o     (ir_shift),
        .ir_update_o    (ir_update),
        .ir_shift_q_o   (ir_shift_q),
        .dr_capture_q_o (dr_capture_q),
        .dr_shift_q_o   (dr_shift_q)
    );

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------

    tap_ir #(.IR_WIDTH(IR_WIDTH)) u_ir (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .soft_rst_n_i (soft_rst_n),
        .tdi_i        (tdi_i),
        .ir_capture_i (ir_capture),
        .ir_shift_i   (ir_shift),
        .ir_update_i  (ir_update),
        .ir_o         (ir),
        .ir_tdo_o     (ir_tdo)
    );

    tap_idcode_reg u_idcode (
        .tapc_tck       (tapc_tck),
        .tapc_trst_n    (tapc_trst_n),
        .soft_rst_n_i   (soft_rst_n),
        .tdi_i          (tdi_i),
        .select_i       (idcode_sel),
        .capture_i      (dr_capture_q),
        .shift_i        (dr_shift_q),
        .capture_data_i (fuse_idcode_i),
        .tdo_o          (idcode_tdo)
    );

    // Register select and serial output
    tap_tdo_out #(.IR_WIDTH(IR_WIDTH)) u_tdo (
        .tapc_tck       (tapc_tck),
        .tapc_trst_n    (tapc_trst_n),
        .soft_rst_n_i   (soft_rst_n),
        .tdi_i          (tdi_i),
        .ir_i           (ir),
        .ir_tdo_i       (ir_tdo),
        .idcode_tdo_i   (idcode_tdo),
        .ir_shift_q_i   (ir_shift_q),
        .dr_capture_q_i (dr_capture_q),
        .dr_shift_q_i   (dr_shift_q),
        .idcode_sel_o   (idcode_sel),
        .tdo_o          (tdo_o),
        .tdo_en_o       (tdo_en_o)
    );

endmodule : tap_top
